// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fpga_bus_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN   := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tests/fpga_bus_tasks.svh

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
+incdir+tests
src/fpga_bus_pkg.sv
src/write_bus_arbiter.sv
src/read_bus_router.sv
src/board_status.sv
src/clock_monitor.sv
src/fpga_bus_top.sv
tests/fpga_bus_tb.sv

// ==== src/board_status.sv ====
`timescale 1ns/1ps

module board_status (
    input  logic                                 clk_200MHz,
    input  logic                                 rst_n_i,
    input  logic                                 ip_reg_wen_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]  reg_wdata_i,
    input  logic                                 clk_ok_i,
    input  logic [fpga_bus_pkg::MON_CNT_W-1:0]   clk_per_i,
    input  logic [fpga_bus_pkg::MON_CNT_W-1:0]   ps_cnt_i,
    input  logic                                 eth_port_i,         // Active Ethernet port
    input  logic [7:0]                           eth_status_io_i,
    input  logic [7:0]                           eth_status_phy1_i,
    input  logic [7:0]                           eth_status_phy2_i,
    input  logic                                 has_irq1_i,         // PHY IRQ line present
    input  logic                                 has_irq2_i,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]  ip_address_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]  eth_result_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]  clk_status_o,
    output logic                                 is_v30_o
);
    import fpga_bus_pkg::*;

    // IP address register
    always_ff @(posedge clk_200MHz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ip_address_o <= '0;
        end else if (ip_reg_wen_i) begin
            ip_address_o <= reg_wdata_i;
        end
    end

    // Result word, revision tag on top, then board, IO and port status bytes
    assign eth_result_o = {ETH_RESULT_REV, eth_port_i, clk_ok_i, 4'h0,
                           eth_status_io_i, eth_status_phy2_i, eth_status_phy1_i};

    // Clock status, read back through PROMSTAT
    assign clk_status_o = {clk_ok_i, 7'd0, clk_per_i, 8'd0, ps_cnt_i};

    // V3.0 boards have no IRQ line to either PHY
    assign is_v30_o = ~(has_irq1_i | has_irq2_i);

endmodule

// ==== src/clock_monitor.sv ====
`timescale 1ns/1ps

module clock_monitor (
    input  logic                                clk_200MHz,
    input  logic                                ps_clk_i,    // Clock under test
    input  logic                                rst_n_i,
    output logic [fpga_bus_pkg::MON_CNT_W-1:0]  ps_cnt_o,
    output logic [fpga_bus_pkg::MON_CNT_W-1:0]  clk_per_o,   // Last half-period, system cycles
    output logic                                clk_ok_o
);
    import fpga_bus_pkg::*;

    logic                 msb_meta;    // First sync stage
    logic                 msb_sync;
    logic                 msb_last;    // For edge detect
    logic                 msb_toggle;
    logic [MON_CNT_W-1:0] cyc_cnt;     // System cycles since last toggle

    // Free-running counter in the ps clock domain
    always_ff @(posedge ps_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ps_cnt_o <= '0;
        end else begin
            ps_cnt_o <= ps_cnt_o + 1'b1;
        end
    end

    // System domain ---------------------
    always_ff @(posedge clk_200MHz or negedge rst_n_i) begin
        if (!rst_n_i) begin
            msb_meta  <= 1'b0;
            msb_sync  <= 1'b0;
            msb_last  <= 1'b0;
            cyc_cnt   <= '0;
            clk_per_o <= '0;
        end else begin
            msb_meta <= ps_cnt_o[MON_CNT_W-1];
            msb_sync <= msb_meta;
            msb_last <= msb_sync;
            if (msb_toggle) begin
                clk_per_o <= cyc_cnt;
                cyc_cnt   <= MON_CNT_W'(1);  // Toggle cycle opens the new half-period
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
            end
        end
    end

    assign msb_toggle = msb_sync ^ msb_last;

    // In range when half-period falls inside the window
    assign clk_ok_o = (clk_per_o >= MON_CNT_W'(CLK_PER_MIN)) &&
                      (clk_per_o <= MON_CNT_W'(CLK_PER_MAX));

    a_per_on_toggle: assert property (@(posedge clk_200MHz) disable iff (!rst_n_i)
        $changed(clk_per_o) |-> $past(msb_toggle));

endmodule

// ==== src/fpga_bus_pkg.sv ====
package fpga_bus_pkg;

    // Bus widths ------------------------
    localparam int REG_ADDR_W    = 16;  // Register address
    localparam int REG_DATA_W    = 32;  // Register data
    localparam int BW_ADDR_W     = 8;   // Block writer only sees the low byte
    localparam int RT_ADDR_W     = 4;   // Real-time write address
    localparam int SAMPLE_ADDR_W = 6;   // Sample buffer address

    // Ethernet ports
    localparam int         NUM_ETH_PORTS  = 2;
    localparam logic [3:0] ETH_PORT_WREG  = 4'hA;   // Port write sub-block, 4pa0
    localparam logic [1:0] ETH_RESULT_REV = 2'b01;  // Result word rev 3 tag

    // Clock monitor ---------------------
    localparam int MON_CNT_W   = 8;
    localparam int CLK_PER_MIN = 30;  // Half-period window in system cycles
    localparam int CLK_PER_MAX = 31;

    // Address space, register address bits 15..12
    typedef enum logic [3:0] {
        ADDR_MAIN = 4'h0,
        ADDR_HUB  = 4'h1,
        ADDR_PROM = 4'h2,
        ADDR_ETH  = 4'h4,
        ADDR_FW   = 4'h5
    } addr_space_e;

    // Board register offsets in channel 0
    typedef enum logic [3:0] {
        REG_PROMSTAT = 4'd8,   // Clock status on V3
        REG_PROMRES  = 4'd9,   // No PROM on V3, reads 0
        REG_IPADDR   = 4'd11,
        REG_ETHRES   = 4'd12
    } chan0_reg_e;

endpackage

// ==== src/fpga_bus_top.sv ====
`timescale 1ns/1ps

module fpga_bus_top (
    input  logic                                    clk_200MHz,
    input  logic                                    rst_n_i,
    input  logic                                    ps_clk_i,
    // Write masters
    input  logic                                    bw_write_en_i,
    input  logic [fpga_bus_pkg::BW_ADDR_W-1:0]      bw_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     bw_reg_wdata_i,
    input  logic                                    bw_reg_wen_i,
    input  logic                                    bw_blk_wen_i,
    input  logic                                    bw_blk_wstart_i,
    input  logic                                    eth_write_en_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     eth_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_reg_wdata_i,
    input  logic                                    eth_reg_wen_i,
    input  logic                                    eth_blk_wen_i,
    input  logic                                    eth_blk_wstart_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     fw_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_reg_wdata_i,
    input  logic                                    fw_reg_wen_i,
    input  logic                                    fw_blk_wen_i,
    input  logic                                    fw_blk_wstart_i,
    input  logic                                    eth_rt_wen_i,
    input  logic [fpga_bus_pkg::RT_ADDR_W-1:0]      eth_rt_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_rt_wdata_i,
    input  logic                                    fw_rt_wen_i,
    input  logic [fpga_bus_pkg::RT_ADDR_W-1:0]      fw_rt_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_rt_wdata_i,
    // Read side
    input  logic                                    sample_busy_i,
    input  logic [3:0]                              sample_chan_i,
    input  logic                                    eth_read_en_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     eth_reg_raddr_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     fw_reg_raddr_i,
    input  logic                                    eth_sample_read_i,
    input  logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  eth_sample_raddr_i,
    input  logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  fw_sample_raddr_i,
    input  logic                                    eth_sample_start_i,
    input  logic                                    fw_sample_start_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     hub_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_io_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_switch_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_phy1_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_phy2_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     ext_rdata_i,
    // Status inputs from the Ethernet engines
    input  logic                                    eth_port_i,
    input  logic [7:0]                              eth_status_io_i,
    input  logic [7:0]                              eth_status_phy1_i,
    input  logic [7:0]                              eth_status_phy2_i,
    input  logic                                    has_irq1_i,
    input  logic                                    has_irq2_i,
    // Bus outputs
    output logic [fpga_bus_pkg::REG_ADDR_W-1:0]     reg_waddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     reg_wdata_o,
    output logic                                    reg_wen_o,
    output logic                                    blk_wen_o,
    output logic                                    blk_wstart_o,
    output logic                                    rt_wen_o,
    output logic [fpga_bus_pkg::RT_ADDR_W-1:0]      rt_waddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     rt_wdata_o,
    output logic [fpga_bus_pkg::NUM_ETH_PORTS-1:0]  eth_port_wen_o,
    output logic [fpga_bus_pkg::REG_ADDR_W-1:0]     reg_raddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     reg_rdata_o,
    output logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  sample_raddr_o,
    output logic                                    sample_start_o,
    output logic                                    led_o,     // PS clock looks healthy
    output logic                                    is_v30_o
);
    import fpga_bus_pkg::*;

    logic                  ip_reg_wen;
    logic                  clk_ok;
    logic [MON_CNT_W-1:0]  clk_per;
    logic [MON_CNT_W-1:0]  ps_cnt;
    logic [REG_DATA_W-1:0] ip_address;
    logic [REG_DATA_W-1:0] eth_result;
    logic [REG_DATA_W-1:0] clk_status;

    assign led_o = clk_ok;

    // Bus ports share names with the top, so most connect by name
    write_bus_arbiter write_bus_arbiter_inst (
        .*,
        .ip_reg_wen_o (ip_reg_wen)
    );

    read_bus_router read_bus_router_inst (
        .*,
        .clk_status_i (clk_status),
        .ip_address_i (ip_address),
        .eth_result_i (eth_result)
    );

    board_status board_status_inst (
        .*,
        .ip_reg_wen_i (ip_reg_wen),
        .reg_wdata_i  (reg_wdata_o),
        .clk_ok_i     (clk_ok),
        .clk_per_i    (clk_per),
        .ps_cnt_i     (ps_cnt),
        .ip_address_o (ip_address),
        .eth_result_o (eth_result),
        .clk_status_o (clk_status)
    );

    clock_monitor clock_monitor_inst (
        .*,
        .ps_cnt_o  (ps_cnt),
        .clk_per_o (clk_per),
        .clk_ok_o  (clk_ok)
    );

endmodule

// ==== src/read_bus_router.sv ====
`timescale 1ns/1ps

module read_bus_router (
    input  logic                                    clk_200MHz,
    input  logic                                    rst_n_i,
    // Read address sources
    input  logic                                    sample_busy_i,  // Sampler owns reg_raddr
    input  logic [3:0]                              sample_chan_i,
    input  logic                                    eth_read_en_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     eth_reg_raddr_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     fw_reg_raddr_i,
    // Sample buffer access
    input  logic                                    eth_sample_read_i,
    input  logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  eth_sample_raddr_i,
    input  logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  fw_sample_raddr_i,
    input  logic                                    eth_sample_start_i,
    input  logic                                    fw_sample_start_i,
    // Read data sources
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     hub_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_io_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_switch_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_phy1_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_phy2_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_rdata_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     ext_rdata_i,
    // Board status words
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     clk_status_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     ip_address_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_result_i,
    output logic [fpga_bus_pkg::REG_ADDR_W-1:0]     reg_raddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     reg_rdata_o,
    output logic [fpga_bus_pkg::SAMPLE_ADDR_W-1:0]  sample_raddr_o,
    output logic                                    sample_start_o
);
    import fpga_bus_pkg::*;

    addr_space_e           rd_space;       // Space of the current read
    chan0_reg_e            rd_reg;         // Offset within channel 0
    logic [REG_DATA_W-1:0] eth_phy_rdata;  // Selected port data
    logic [REG_DATA_W-1:0] chan0_rdata;

    // Address selection -----------------
    assign reg_raddr_o = sample_busy_i ? {ADDR_MAIN, 4'd0, sample_chan_i, 4'd0} :
                         eth_read_en_i ? eth_reg_raddr_i :
                         fw_reg_raddr_i;

    assign sample_raddr_o = eth_sample_read_i ? eth_sample_raddr_i : fw_sample_raddr_i;
    assign sample_start_o = (eth_sample_start_i | fw_sample_start_i) & ~sample_busy_i;

    assign rd_space = addr_space_e'(reg_raddr_o[15:12]);
    assign rd_reg   = chan0_reg_e'(reg_raddr_o[3:0]);

    // Data routing ----------------------
    // Port number sits in bits 11..8 of an eth address
    always_comb begin
        case (reg_raddr_o[11:8])
            4'd1:    eth_phy_rdata = eth_phy1_rdata_i;
            4'd2:    eth_phy_rdata = eth_phy2_rdata_i;
            default: eth_phy_rdata = '0;  // No such port
        endcase
    end

    always_comb begin
        case (rd_reg)
            REG_PROMSTAT: chan0_rdata = clk_status_i;
            REG_PROMRES:  chan0_rdata = '0;
            REG_IPADDR:   chan0_rdata = ip_address_i;
            REG_ETHRES:   chan0_rdata = eth_result_i;
            default:      chan0_rdata = ext_rdata_i;  // Rest of channel 0 lives off-chip
        endcase
    end

    always_comb begin
        case (rd_space)
            ADDR_HUB:  reg_rdata_o = hub_rdata_i;
            ADDR_PROM: reg_rdata_o = '0;
            ADDR_ETH:  reg_rdata_o = eth_io_rdata_i | eth_switch_rdata_i | eth_phy_rdata;
            ADDR_FW:   reg_rdata_o = fw_rdata_i;
            // Only channel 0 of main space is on this chip
            ADDR_MAIN: reg_rdata_o = (reg_raddr_o[7:4] == 4'd0) ? chan0_rdata : ext_rdata_i;
            default:   reg_rdata_o = ext_rdata_i;
        endcase
    end

    a_no_start_when_busy: assert property (@(posedge clk_200MHz) disable iff (!rst_n_i)
        sample_busy_i |-> !sample_start_o);

endmodule

// ==== src/write_bus_arbiter.sv ====
`timescale 1ns/1ps

module write_bus_arbiter (
    input  logic                                    clk_200MHz,
    input  logic                                    rst_n_i,
    // Block writer, highest priority
    input  logic                                    bw_write_en_i,
    input  logic [fpga_bus_pkg::BW_ADDR_W-1:0]      bw_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     bw_reg_wdata_i,
    input  logic                                    bw_reg_wen_i,
    input  logic                                    bw_blk_wen_i,
    input  logic                                    bw_blk_wstart_i,
    // Ethernet
    input  logic                                    eth_write_en_i,
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     eth_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_reg_wdata_i,
    input  logic                                    eth_reg_wen_i,
    input  logic                                    eth_blk_wen_i,
    input  logic                                    eth_blk_wstart_i,
    // FireWire, owns the bus by default
    input  logic [fpga_bus_pkg::REG_ADDR_W-1:0]     fw_reg_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_reg_wdata_i,
    input  logic                                    fw_reg_wen_i,
    input  logic                                    fw_blk_wen_i,
    input  logic                                    fw_blk_wstart_i,
    // Real-time writes
    input  logic                                    eth_rt_wen_i,
    input  logic [fpga_bus_pkg::RT_ADDR_W-1:0]      eth_rt_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     eth_rt_wdata_i,
    input  logic                                    fw_rt_wen_i,
    input  logic [fpga_bus_pkg::RT_ADDR_W-1:0]      fw_rt_waddr_i,
    input  logic [fpga_bus_pkg::REG_DATA_W-1:0]     fw_rt_wdata_i,
    // Shared write bus
    output logic [fpga_bus_pkg::REG_ADDR_W-1:0]     reg_waddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     reg_wdata_o,
    output logic                                    reg_wen_o,
    output logic                                    blk_wen_o,
    output logic                                    blk_wstart_o,
    output logic                                    rt_wen_o,
    output logic [fpga_bus_pkg::RT_ADDR_W-1:0]      rt_waddr_o,
    output logic [fpga_bus_pkg::REG_DATA_W-1:0]     rt_wdata_o,
    output logic [fpga_bus_pkg::NUM_ETH_PORTS-1:0]  eth_port_wen_o,
    output logic                                    ip_reg_wen_o
);
    import fpga_bus_pkg::*;

    typedef enum logic [1:0] {SRC_FW, SRC_ETH, SRC_BW} wsrc_e;

    wsrc_e wsrc;  // Current write bus owner

    // Priority encoder: bw > eth > fw
    always_comb begin
        if (bw_write_en_i) begin
            wsrc = SRC_BW;
        end else if (eth_write_en_i) begin
            wsrc = SRC_ETH;
        end else begin
            wsrc = SRC_FW;
        end
    end

    always_comb begin
        case (wsrc)
            SRC_BW: begin
                reg_waddr_o  = {{(REG_ADDR_W-BW_ADDR_W){1'b0}}, bw_reg_waddr_i};  // Zero-extend
                reg_wdata_o  = bw_reg_wdata_i;
                reg_wen_o    = bw_reg_wen_i;
                blk_wen_o    = bw_blk_wen_i;
                blk_wstart_o = bw_blk_wstart_i;
            end
            SRC_ETH: begin
                reg_waddr_o  = eth_reg_waddr_i;
                reg_wdata_o  = eth_reg_wdata_i;
                reg_wen_o    = eth_reg_wen_i;
                blk_wen_o    = eth_blk_wen_i;
                blk_wstart_o = eth_blk_wstart_i;
            end
            default: begin
                reg_waddr_o  = fw_reg_waddr_i;
                reg_wdata_o  = fw_reg_wdata_i;
                reg_wen_o    = fw_reg_wen_i;
                blk_wen_o    = fw_blk_wen_i;
                blk_wstart_o = fw_blk_wstart_i;
            end
        endcase
    end

    // Real-time write, eth wins whenever it is writing
    assign rt_wen_o   = eth_rt_wen_i ? eth_rt_wen_i   : fw_rt_wen_i;
    assign rt_waddr_o = eth_rt_wen_i ? eth_rt_waddr_i : fw_rt_waddr_i;
    assign rt_wdata_o = eth_rt_wen_i ? eth_rt_wdata_i : fw_rt_wdata_i;

    // Port p owns 4pa0..4paf
    for (genvar p = 0; p < NUM_ETH_PORTS; p++) begin : g_port_wen
        localparam logic [3:0] PORT_NUM = 4'(p + 1);
        assign eth_port_wen_o[p] = reg_wen_o &&
            (reg_waddr_o[15:4] == {ADDR_ETH, PORT_NUM, ETH_PORT_WREG});
    end

    assign ip_reg_wen_o = reg_wen_o && (reg_waddr_o == {ADDR_MAIN, 8'h00, REG_IPADDR});

    a_port_wen_onehot: assert property (@(posedge clk_200MHz) disable iff (!rst_n_i)
        $onehot0(eth_port_wen_o));

endmodule

// ==== tests/fpga_bus_tasks.svh ====
// Checks and reporting ----------------
task automatic check_value(input string name, input logic [63:0] expected,
                           input logic [63:0] actual);
    checks++;
    assert (actual === expected) else begin
        $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
        errors++;
    end
endtask

task automatic report_test(input string name, input int errs_before);
    tests_run++;
    if (errors == errs_before) begin
        $display("%s: ok", name);
    end else begin
        $display("%s: %0d errors", name, errors - errs_before);
    end
endtask

// Read data expected from the address map, chan0 status offsets not covered here
function automatic logic [31:0] expected_rdata(input logic [15:0] addr);
    logic [31:0] port_data;
    port_data = (addr[11:8] == 4'd1) ? eth_phy1_rdata_i :
                (addr[11:8] == 4'd2) ? eth_phy2_rdata_i : 32'd0;
    case (addr[15:12])
        ADDR_HUB:  return hub_rdata_i;
        ADDR_PROM: return 32'd0;
        ADDR_ETH:  return eth_io_rdata_i | eth_switch_rdata_i | port_data;
        ADDR_FW:   return fw_rdata_i;
        ADDR_MAIN: return (addr[7:0] == {4'd0, REG_PROMRES}) ? 32'd0 : ext_rdata_i;
        default:   return ext_rdata_i;
    endcase
endfunction

// Directed tests ----------------------
task automatic clock_rate_check();
    int         errs_before;
    int         waited;
    logic [7:0] per;
    errs_before = errors;
    check_value("clock_rate_check", 64'(0), 64'(led_o));  // Slow PS clock since reset
    ps_half = 12.0;  // 24 ns period, half-period near 30.7 system cycles
    waited  = 0;
    while (!led_o && waited < 2000) begin
        @(negedge clk_200MHz);
        waited++;
    end
    assert (led_o) else begin
        $display("clock_rate_check: led_o did not rise within 2000 cycles");
        errors++;
    end
    @(posedge clk_200MHz);
    eth_read_en_i   <= 1'b1;
    eth_reg_raddr_i <= {ADDR_MAIN, 8'h00, REG_PROMSTAT};
    @(negedge clk_200MHz);
    per = reg_rdata_o[23:16];
    checks++;
    assert (per == 8'd30 || per == 8'd31) else begin
        $display("CHECK FAILED clock_rate_check: expected 30 or 31, actual %0d", per);
        errors++;
    end
    ps_half = 25.0;  // Back to 50 ns, 64 cycles per half-period
    waited  = 0;
    while (led_o && waited < 2000) begin
        @(negedge clk_200MHz);
        waited++;
    end
    assert (!led_o) else begin
        $display("clock_rate_check: led_o did not fall within 2000 cycles");
        errors++;
    end
    report_test("clock_rate_check", errs_before);
endtask

task automatic write_priority();
    int          errs_before;
    logic [50:0] exp_bus;  // {addr, data, reg_wen, blk_wen, blk_wstart}
    logic [36:0] exp_rt;
    errs_before = errors;
    for (int i = 0; i < 16; i++) begin
        @(posedge clk_200MHz);
        bw_write_en_i   <= i[0];
        eth_write_en_i  <= i[1];
        eth_rt_wen_i    <= i[2];
        bw_reg_waddr_i  <= 8'($random(seed));
        eth_reg_waddr_i <= 16'($random(seed));
        fw_reg_waddr_i  <= 16'($random(seed));
        bw_reg_wdata_i  <= $random(seed);
        eth_reg_wdata_i <= $random(seed);
        fw_reg_wdata_i  <= $random(seed);
        {bw_reg_wen_i, bw_blk_wen_i, bw_blk_wstart_i}    <= 3'($random(seed));
        {eth_reg_wen_i, eth_blk_wen_i, eth_blk_wstart_i} <= 3'($random(seed));
        {fw_reg_wen_i, fw_blk_wen_i, fw_blk_wstart_i}    <= 3'($random(seed));
        fw_rt_wen_i     <= 1'($random(seed));
        eth_rt_waddr_i  <= 4'($random(seed));
        fw_rt_waddr_i   <= 4'($random(seed));
        eth_rt_wdata_i  <= $random(seed);
        fw_rt_wdata_i   <= $random(seed);
        @(negedge clk_200MHz);
        if (bw_write_en_i) begin
            exp_bus = {8'h00, bw_reg_waddr_i, bw_reg_wdata_i,
                       bw_reg_wen_i, bw_blk_wen_i, bw_blk_wstart_i};
        end else if (eth_write_en_i) begin
            exp_bus = {eth_reg_waddr_i, eth_reg_wdata_i,
                       eth_reg_wen_i, eth_blk_wen_i, eth_blk_wstart_i};
        end else begin
            exp_bus = {fw_reg_waddr_i, fw_reg_wdata_i,
                       fw_reg_wen_i, fw_blk_wen_i, fw_blk_wstart_i};
        end
        exp_rt = eth_rt_wen_i ? {1'b1, eth_rt_waddr_i, eth_rt_wdata_i} :
                                {fw_rt_wen_i, fw_rt_waddr_i, fw_rt_wdata_i};
        check_value("write_priority", 64'(exp_bus),
                    64'({reg_waddr_o, reg_wdata_o, reg_wen_o, blk_wen_o, blk_wstart_o}));
        check_value("write_priority", 64'(exp_rt), 64'({rt_wen_o, rt_waddr_o, rt_wdata_o}));
    end
    @(posedge clk_200MHz);
    {bw_write_en_i, eth_write_en_i, bw_reg_wen_i, eth_reg_wen_i, fw_reg_wen_i} <= '0;
    report_test("write_priority", errs_before);
endtask

task automatic read_address_select();
    int                    errs_before;
    logic [REG_ADDR_W-1:0] exp_raddr;
    errs_before = errors;
    for (int i = 0; i < 16; i++) begin
        @(posedge clk_200MHz);
        sample_busy_i      <= i[0];
        eth_read_en_i      <= i[1];
        eth_sample_read_i  <= i[2];
        {eth_sample_start_i, fw_sample_start_i} <= 2'($random(seed));
        sample_chan_i      <= 4'($random(seed));
        eth_reg_raddr_i    <= 16'($random(seed));
        fw_reg_raddr_i     <= 16'($random(seed));
        eth_sample_raddr_i <= 6'($random(seed));
        fw_sample_raddr_i  <= 6'($random(seed));
        @(negedge clk_200MHz);
        if (sample_busy_i) begin
            exp_raddr = {8'h00, sample_chan_i, 4'h0};  // Main space, channel address
        end else if (eth_read_en_i) begin
            exp_raddr = eth_reg_raddr_i;
        end else begin
            exp_raddr = fw_reg_raddr_i;
        end
        check_value("read_address_select", 64'(exp_raddr), 64'(reg_raddr_o));
        check_value("read_address_select",
                    64'(eth_sample_read_i ? eth_sample_raddr_i : fw_sample_raddr_i),
                    64'(sample_raddr_o));
        check_value("read_address_select",
                    64'((eth_sample_start_i | fw_sample_start_i) & ~sample_busy_i),
                    64'(sample_start_o));
    end
    @(posedge clk_200MHz);
    sample_busy_i <= 1'b0;
    eth_read_en_i <= 1'b1;  // eth owns reads from here on
    report_test("read_address_select", errs_before);
endtask

task automatic read_data_routing();
    int          errs_before;
    logic [15:0] addrs [12] = '{16'h1234, 16'h2ff0, 16'h4100, 16'h4255, 16'h43a0, 16'h4f00,
                                16'h5abc, 16'h0018, 16'h0049, 16'h0009, 16'h0003, 16'h7001};
    errs_before = errors;
    foreach (addrs[k]) begin
        @(posedge clk_200MHz);
        eth_reg_raddr_i    <= addrs[k];
        hub_rdata_i        <= $random(seed);
        eth_io_rdata_i     <= $random(seed);
        eth_switch_rdata_i <= $random(seed);
        eth_phy1_rdata_i   <= $random(seed);
        eth_phy2_rdata_i   <= $random(seed);
        fw_rdata_i         <= $random(seed);
        ext_rdata_i        <= $random(seed);
        @(negedge clk_200MHz);
        check_value("read_data_routing", 64'(expected_rdata(addrs[k])), 64'(reg_rdata_o));
    end
    report_test("read_data_routing", errs_before);
endtask

task automatic ip_and_port_decode();
    int                    errs_before;
    logic [REG_DATA_W-1:0] ip_word;
    errs_before = errors;
    ip_word     = $random(seed);
    @(posedge clk_200MHz);
    eth_write_en_i  <= 1'b1;
    eth_reg_waddr_i <= {ADDR_MAIN, 8'h00, REG_IPADDR};
    eth_reg_wdata_i <= ip_word;
    eth_reg_wen_i   <= 1'b1;
    eth_reg_raddr_i <= {ADDR_MAIN, 8'h00, REG_IPADDR};
    @(negedge clk_200MHz);
    check_value("ip_and_port_decode", 64'(0), 64'(eth_port_wen_o));
    @(posedge clk_200MHz);  // IP register loads here
    eth_reg_wen_i <= 1'b0;
    @(negedge clk_200MHz);
    check_value("ip_and_port_decode", 64'(ip_word), 64'(reg_rdata_o));
    for (int p = 1; p <= 2; p++) begin
        @(posedge clk_200MHz);
        eth_reg_waddr_i <= {ADDR_ETH, 4'(p), ETH_PORT_WREG, 4'($random(seed))};
        eth_reg_wen_i   <= 1'b1;
        @(negedge clk_200MHz);
        // Port 1 is bit 0 and port 2 bit 1, so the one-hot value equals p
        check_value("ip_and_port_decode", 64'(p), 64'(eth_port_wen_o));
    end
    @(posedge clk_200MHz);
    eth_reg_wen_i <= 1'b0;
    report_test("ip_and_port_decode", errs_before);
endtask

task automatic status_words();
    int errs_before;
    errs_before = errors;
    @(posedge clk_200MHz);
    eth_port_i        <= 1'b1;
    eth_status_io_i   <= 8'hA5;
    eth_status_phy1_i <= 8'h3C;
    eth_status_phy2_i <= 8'h96;
    eth_reg_raddr_i   <= {ADDR_MAIN, 8'h00, REG_ETHRES};
    @(negedge clk_200MHz);
    // PS clock is slow again, so the clk_ok bit reads 0
    check_value("status_words", 64'({ETH_RESULT_REV, 1'b1, 1'b0, 4'h0, 8'hA5, 8'h96, 8'h3C}),
                64'(reg_rdata_o));
    for (int i = 0; i < 4; i++) begin
        @(posedge clk_200MHz);
        {has_irq2_i, has_irq1_i} <= i[1:0];
        @(negedge clk_200MHz);
        check_value("status_words", 64'(i == 0), 64'(is_v30_o));  // V3.0 only with no IRQs
    end
    report_test("status_words", errs_before);
endtask

// ==== tests/fpga_bus_tb.sv ====
`timescale 1ns/1ps

module fpga_bus_tb;
    import fpga_bus_pkg::*;

    // DUT inputs ------------------------
    logic                     clk_200MHz;
    logic                     rst_n_i;
    logic                     ps_clk_i;               // Monitored PS clock
    logic                     bw_write_en_i, bw_reg_wen_i, bw_blk_wen_i, bw_blk_wstart_i;
    logic [BW_ADDR_W-1:0]     bw_reg_waddr_i;
    logic [REG_DATA_W-1:0]    bw_reg_wdata_i;
    logic                     eth_write_en_i, eth_reg_wen_i, eth_blk_wen_i, eth_blk_wstart_i;
    logic                     fw_reg_wen_i, fw_blk_wen_i, fw_blk_wstart_i;
    logic [REG_ADDR_W-1:0]    eth_reg_waddr_i, fw_reg_waddr_i;
    logic [REG_DATA_W-1:0]    eth_reg_wdata_i, fw_reg_wdata_i;
    logic                     eth_rt_wen_i, fw_rt_wen_i;
    logic [RT_ADDR_W-1:0]     eth_rt_waddr_i, fw_rt_waddr_i;
    logic [REG_DATA_W-1:0]    eth_rt_wdata_i, fw_rt_wdata_i;
    logic                     sample_busy_i, eth_read_en_i, eth_sample_read_i;
    logic                     eth_sample_start_i, fw_sample_start_i;
    logic [3:0]               sample_chan_i;
    logic [REG_ADDR_W-1:0]    eth_reg_raddr_i, fw_reg_raddr_i;
    logic [SAMPLE_ADDR_W-1:0] eth_sample_raddr_i, fw_sample_raddr_i;
    logic [REG_DATA_W-1:0]    hub_rdata_i, eth_io_rdata_i, eth_switch_rdata_i;
    logic [REG_DATA_W-1:0]    eth_phy1_rdata_i, eth_phy2_rdata_i, fw_rdata_i, ext_rdata_i;
    logic                     eth_port_i, has_irq1_i, has_irq2_i;
    logic [7:0]               eth_status_io_i, eth_status_phy1_i, eth_status_phy2_i;

    // DUT outputs
    logic [REG_ADDR_W-1:0]    reg_waddr_o, reg_raddr_o;
    logic [REG_DATA_W-1:0]    reg_wdata_o, rt_wdata_o, reg_rdata_o;
    logic                     reg_wen_o, blk_wen_o, blk_wstart_o, rt_wen_o;
    logic                     sample_start_o, led_o, is_v30_o;
    logic [RT_ADDR_W-1:0]     rt_waddr_o;
    logic [NUM_ETH_PORTS-1:0] eth_port_wen_o;
    logic [SAMPLE_ADDR_W-1:0] sample_raddr_o;

    int      seed      = 62091;
    int      errors    = 0;
    int      checks    = 0;
    int      tests_run = 0;
    realtime ps_half   = 25.0;  // 50 ns PS clock, well outside the window

    fpga_bus_top fpga_bus_top_inst (.*);  // Ports and tb signals share names

    always #50 clk_200MHz = ~clk_200MHz;  // 100 ns system clock
    always #(ps_half) ps_clk_i = ~ps_clk_i;

    `include "fpga_bus_tasks.svh"

    initial begin
        clk_200MHz = 1'b0;
        ps_clk_i   = 1'b0;
        rst_n_i    = 1'b0;
        {bw_write_en_i, bw_reg_wen_i, bw_blk_wen_i, bw_blk_wstart_i, bw_reg_waddr_i,
         bw_reg_wdata_i, eth_write_en_i, eth_reg_wen_i, eth_blk_wen_i, eth_blk_wstart_i,
         fw_reg_wen_i, fw_blk_wen_i, fw_blk_wstart_i, eth_reg_waddr_i, fw_reg_waddr_i,
         eth_reg_wdata_i, fw_reg_wdata_i} = '0;
        {eth_rt_wen_i, fw_rt_wen_i, eth_rt_waddr_i, fw_rt_waddr_i, eth_rt_wdata_i,
         fw_rt_wdata_i, sample_busy_i, eth_read_en_i, eth_sample_read_i,
         eth_sample_start_i, fw_sample_start_i, sample_chan_i, eth_reg_raddr_i,
         fw_reg_raddr_i, eth_sample_raddr_i, fw_sample_raddr_i} = '0;
        {hub_rdata_i, eth_io_rdata_i, eth_switch_rdata_i, eth_phy1_rdata_i,
         eth_phy2_rdata_i, fw_rdata_i, ext_rdata_i, eth_port_i, has_irq1_i, has_irq2_i,
         eth_status_io_i, eth_status_phy1_i, eth_status_phy2_i} = '0;

        repeat (16) @(posedge clk_200MHz);
        rst_n_i <= 1'b1;
        @(negedge clk_200MHz);

        // Monitor goes first, led_o is checked straight out of reset
        clock_rate_check();
        write_priority();
        read_address_select();
        read_data_routing();
        ip_and_port_decode();
        status_words();

        $display("%0d tests run, %0d checks, %0d errors", tests_run, checks, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule
